//--- Bender.yml
package:
  name: busCpu

sources:
  - logic/cpuPkg.sv
  - logic/regFile.sv
  - logic/aluUnit.sv
  - logic/busDatapath.sv
  - logic/controlSequencer.sv
  - logic/cpuTop.sv
  - target: test
    files:
      - tests/cpuTop_sva.sv
      - tests/cpuTb.sv

//--- logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  cpuPkg::opcode_t op,
    input  logic [31:0]     yValue,
    input  logic [31:0]     busValue,
    output logic [31:0]     result
);

    import cpuPkg::*;

    // Shift amount from the low bus bits
    logic [4:0] shiftAmt;

    assign shiftAmt = busValue[4:0];

    always_comb begin
        case (op)
            // ld adds base and offset like add
            add, addi, ld: begin
                result = yValue + busValue;
            end
            sub: begin
                result = yValue - busValue;
            end
            andOp, andi: begin
                result = yValue & busValue;
            end
            orOp, ori: begin
                result = yValue | busValue;
            end
            // Logical shifts, Y is the shifted value
            shl: begin
                result = yValue << shiftAmt;
            end
            shr: begin
                result = yValue >> shiftAmt;
            end
            // Unary ops work on the bus only
            notOp: begin
                result = ~busValue;
            end
            neg: begin
                result = -busValue;
            end
            // PC increment during fetch
            incOp: begin
                result = busValue + 32'd1;
            end
            default: begin
                // Pass the bus through
                result = busValue;
            end
        endcase
    end

endmodule

//--- logic/busDatapath.sv
`timescale 1ns/1ps

module busDatapath #(
    parameter logic [31:0] resetPc = 32'd0
) (
    input  logic              clock,
    input  logic              rstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  logic [31:0]       memData,
    output cpuPkg::instr_t    ir,
    output logic [31:0]       memAddr,
    output logic              memRead,
    output logic [31:0]       outPort,
    output logic              outStrobe
);

    import cpuPkg::*;

    // The shared bus and its source registers
    logic [31:0] bus;
    logic [31:0] pc;
    logic [31:0] mar;
    logic [31:0] mdr;
    logic [31:0] yReg;
    logic [31:0] zReg;
    instr_t      irReg;

    // Register file and ALU hookup
    logic [3:0]  regAddr;
    logic [31:0] regData;
    logic [31:0] aluResult;
    logic [31:0] immExt;
    opcode_t     aluOp;

    // High in T2, MDR then holds the fresh instruction
    logic        fetchDone;

    // Sign-extended 15-bit immediate
    assign immExt = {{17{irReg.imm[14]}}, irReg.imm};

    // Bus multiplexer, one source per cycle
    always_comb begin
        case (ctrl.busSrc)
            srcPc:   bus = pc;
            srcZ:    bus = zReg;
            srcMdr:  bus = mdr;
            srcReg:  bus = regData;
            srcImm:  bus = immExt;
            default: bus = '0;
        endcase
    end

    // Register address from the selected IR field
    always_comb begin
        case (ctrl.regSel)
            selRb:   regAddr = irReg.rb;
            selRc:   regAddr = irReg.rc;
            default: regAddr = irReg.ra;
        endcase
    end

    // incPc overrides the decoded ALU op
    assign aluOp = ctrl.incPc ? incOp : ctrl.aluOp;

    regFile regFile_i (
        .clock    (clock),
        .rstN     (rstN),
        .addr     (regAddr),
        .writeEn  (ctrl.regIn),
        .busIn    (bus),
        .readData (regData)
    );

    aluUnit aluUnit_i (
        .op       (aluOp),
        .yValue   (yReg),
        .busValue (bus),
        .result   (aluResult)
    );

    // Bus registers, each on its own strobe
    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc        <= resetPc;
            mar       <= '0;
            mdr       <= '0;
            yReg      <= '0;
            zReg      <= '0;
            irReg     <= '0;
            outPort   <= '0;
            outStrobe <= 1'b0;
            fetchDone <= 1'b0;
        end else begin
            if (ctrl.pcIn) pc <= bus;
            if (ctrl.marIn) mar <= bus;
            // MDR takes the word memory returns
            if (ctrl.mdrIn) mdr <= memData;
            if (ctrl.yIn) yReg <= bus;
            if (ctrl.zIn) zReg <= aluResult;
            if (ctrl.irIn) irReg <= instr_t'(bus);
            if (ctrl.outIn) outPort <= bus;
            // One-cycle pulse after the port load
            outStrobe <= ctrl.outIn;
            // Only the fetch read loads PC in the same cycle
            fetchDone <= ctrl.pcIn & ctrl.memRead;
        end
    end

    // IR view for the sequencer, MDR forwarded during T2
    // so the branch after T2 sees the new opcode
    assign ir = fetchDone ? instr_t'(mdr) : irReg;

    // Memory port
    assign memAddr = mar;
    assign memRead = ctrl.memRead;

endmodule

//--- logic/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
    input  logic              clock,
    input  logic              rstN,
    input  cpuPkg::instr_t    ir,
    output cpuPkg::ctrlWord_t ctrl,
    output logic              halted
);

    import cpuPkg::*;

    // Opcode groups that share a state path
    typedef enum logic [2:0] {
        grpAlu, grpImm, grpLd, grpOut, grpNop, grpHalt
    } group_t;

    state_t state;
    state_t nextState;
    group_t grp;

    // Group decode, unknown codes run as nop
    always_comb begin
        case (ir.opcode)
            add, sub, andOp, orOp, shl, shr, notOp, neg: grp = grpAlu;
            addi, andi, ori: grp = grpImm;
            ld:      grp = grpLd;
            out:     grp = grpOut;
            halt:    grp = grpHalt;
            default: grp = grpNop;
        endcase
    end

    // Next timing state
    always_comb begin
        case (state)
            idle: nextState = t0;
            t0:   nextState = t1;
            t1:   nextState = t2;
            t2: begin
                if (grp == grpNop) nextState = t0;
                else if (grp == grpHalt) nextState = haltState;
                else nextState = t3;
            end
            // out is done after T3
            t3:   nextState = (grp == grpOut) ? t0 : t4;
            t4:   nextState = t5;
            // only ld goes on past T5
            t5:   nextState = (grp == grpLd) ? t6 : t0;
            t6:   nextState = t7;
            t7:   nextState = t0;
            // Stuck until reset
            haltState: nextState = haltState;
            default:   nextState = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // Control word for the current state
    always_comb begin
        ctrl        = '0;
        ctrl.busSrc = srcNone;
        ctrl.regSel = selRa;
        ctrl.aluOp  = nop;
        case (state)
            // Fetch: PC to MAR, Z gets PC plus one
            t0: begin
                ctrl.busSrc = srcPc;
                ctrl.marIn  = 1'b1;
                ctrl.incPc  = 1'b1;
                ctrl.zIn    = 1'b1;
            end
            t1: begin
                ctrl.busSrc  = srcZ;
                ctrl.pcIn    = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.mdrIn   = 1'b1;
            end
            t2: begin
                ctrl.busSrc = srcMdr;
                ctrl.irIn   = 1'b1;
            end
            // Ra to port for out, else Rb into Y
            t3: begin
                ctrl.busSrc = srcReg;
                if (grp == grpOut) begin
                    ctrl.regSel = selRa;
                    ctrl.outIn  = 1'b1;
                end else begin
                    ctrl.regSel = selRb;
                    ctrl.yIn    = 1'b1;
                end
            end
            // Second operand, Rc or the immediate
            t4: begin
                ctrl.busSrc = (grp == grpAlu) ? srcReg : srcImm;
                ctrl.regSel = selRc;
                ctrl.aluOp  = ir.opcode;
                ctrl.zIn    = 1'b1;
            end
            // Result to Ra, or the ld address to MAR
            t5: begin
                ctrl.busSrc = srcZ;
                if (grp == grpLd) begin
                    ctrl.marIn = 1'b1;
                end else begin
                    ctrl.regIn = 1'b1;
                end
            end
            t6: begin
                ctrl.memRead = 1'b1;
                ctrl.mdrIn   = 1'b1;
            end
            t7: begin
                ctrl.busSrc = srcMdr;
                ctrl.regIn  = 1'b1;
            end
            default: begin
                // idle and haltState stay quiet
                ctrl.busSrc = srcNone;
            end
        endcase
    end

    assign halted = (state == haltState);

endmodule

//--- logic/cpuPkg.sv
package cpuPkg;

    // Instruction opcodes, top five bits of the word
    typedef enum logic [4:0] {
        ld    = 5'b00000,
        add   = 5'b00011,
        sub   = 5'b00100,
        andOp = 5'b00101,
        orOp  = 5'b00110,
        shr   = 5'b01001,
        shl   = 5'b01011,
        addi  = 5'b01100,
        andi  = 5'b01101,
        ori   = 5'b01110,
        neg   = 5'b10001,
        notOp = 5'b10010,
        out   = 5'b10111,
        nop   = 5'b11010,
        halt  = 5'b11011,
        // ALU only, used for the PC increment in T0
        incOp = 5'b11111
    } opcode_t;

    // Sequencer timing states
    typedef enum logic [3:0] {
        idle, t0, t1, t2, t3, t4, t5, t6, t7, haltState
    } state_t;

    // Which register drives the shared bus
    typedef enum logic [2:0] {
        srcNone, srcPc, srcZ, srcMdr, srcReg, srcImm
    } busSrc_t;

    // IR field that addresses the register file
    typedef enum logic [1:0] {
        selRa, selRb, selRc
    } regSel_t;

    // Instruction word layout, MSB first
    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [14:0] imm;
    } instr_t;

    // One control word per cycle
    typedef struct packed {
        busSrc_t busSrc;
        regSel_t regSel;
        opcode_t aluOp;
        logic    marIn;
        logic    pcIn;
        logic    incPc;
        logic    mdrIn;
        logic    memRead;
        logic    irIn;
        logic    yIn;
        logic    zIn;
        logic    regIn;
        logic    outIn;
    } ctrlWord_t;

endpackage

//--- logic/cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
    parameter logic [31:0] resetPc = 32'd0
) (
    input  logic        clock,
    input  logic        rstN,
    input  logic [31:0] memData,
    output logic [31:0] memAddr,
    output logic        memRead,
    output logic [31:0] outPort,
    output logic        outStrobe,
    output logic        halted
);

    import cpuPkg::*;

    // Sequencer to datapath and back
    ctrlWord_t ctrl;
    instr_t    ir;

    controlSequencer controlSequencer_i (
        .clock  (clock),
        .rstN   (rstN),
        .ir     (ir),
        .ctrl   (ctrl),
        .halted (halted)
    );

    busDatapath #(
        .resetPc (resetPc)
    ) busDatapath_i (
        .clock     (clock),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .memData   (memData),
        .ir        (ir),
        .memAddr   (memAddr),
        .memRead   (memRead),
        .outPort   (outPort),
        .outStrobe (outStrobe)
    );

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clock,
    input  logic        rstN,
    input  logic [3:0]  addr,
    input  logic        writeEn,
    input  logic [31:0] busIn,
    output logic [31:0] readData
);

    // Sixteen general registers
    logic [31:0] regs [16];

    // Write port, loads from the bus
    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            // R0 keeps the write but never shows it
            regs[addr] <= busIn;
        end
    end

    // Combinational read port
    always_comb begin
        if (addr == 4'd0) begin
            // R0 is hardwired to zero on read
            readData = '0;
        end else begin
            readData = regs[addr];
        end
    end

endmodule

//--- tests/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    import cpuPkg::*;

    // First fetch address handed to the DUT
    localparam logic [31:0] startPc = 32'd0;

    logic        clock;
    logic        rstN;
    logic [31:0] memData;
    logic [31:0] memAddr;
    logic        memRead;
    logic [31:0] outPort;
    logic        outStrobe;
    logic        halted;

    // Memory image and expected port values from the cases file
    logic [31:0] mem [256];
    logic [31:0] expected [$];
    int          imageTop;
    int          imageWords;
    int          errorCount;
    int          checkCount;
    int          strobeCount;
    logic [31:0] fetchAddr;
    logic        dataReadNext;
    logic        haltSeen;
    logic        imageLoaded;

    cpuTop #(
        .resetPc (startPc)
    ) cpuTop_i (
        .clock     (clock),
        .rstN      (rstN),
        .memData   (memData),
        .memAddr   (memAddr),
        .memRead   (memRead),
        .outPort   (outPort),
        .outStrobe (outStrobe),
        .halted    (halted)
    );

    // Memory answers in the same cycle
    assign memData = mem[memAddr[7:0]];

    initial clock = 1'b0;
    always #10 clock = ~clock;

    task automatic loadImage();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] a;
        logic [31:0] d;
        // Unused words carry their own address
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hA5A5_0000 ^ i;
        end
        fd = $fopen("tests/cpu_cases.mem", "r");
        if (fd == 0) begin
            $display("could not open tests/cpu_cases.mem");
        end else begin
            while ($fgets(line, fd)) begin
                n = $sscanf(line, "%c %h %h", tag, a, d);
                if (tag == "m" && n == 3) begin
                    mem[a[7:0]] = d;
                    imageWords++;
                    if (a > imageTop) imageTop = a;
                end else if (tag == "e" && n >= 2) begin
                    expected.push_back(a);
                end
            end
            $fclose(fd);
            imageLoaded = 1'b1;
        end
    endtask

    task automatic checkQuiet();
        checkCount++;
        if (outStrobe !== 1'b0 || memRead !== 1'b0 || halted !== 1'b0) begin
            $display("[ERROR] %0t: port strobe active around reset", $time);
            errorCount++;
        end
    endtask

    // Watchdog, eight cycles per image word plus reset and margin
    initial begin
        longint limitNs;
        wait (imageLoaded === 1'b1);
        limitNs = (imageWords * 8 + 10 + 60) * 20;
        #(limitNs);
        $display("timeout, the CPU never reached halt");
        $display("CHECKS FAILED");
        $finish;
    end

    // Fetch order, output values and post-halt silence
    always @(posedge clock) begin
        if (rstN === 1'b1) begin
            if (haltSeen && halted !== 1'b1) begin
                $display("[ERROR] %0t: halted dropped before reset", $time);
                errorCount++;
            end
            if (memRead === 1'b1) begin
                if (haltSeen) begin
                    $display("memory was read after the CPU halted");
                    errorCount++;
                end
                if (memAddr > imageTop) begin
                    $display("memory read at %h is beyond the loaded image", memAddr);
                    errorCount++;
                end
                if (dataReadNext) begin
                    dataReadNext = 1'b0;
                end else begin
                    checkCount++;
                    if (memAddr !== fetchAddr) begin
                        $display("[ERROR] %0t: fetch from %h, expected %h", $time, memAddr,
                                 fetchAddr);
                        errorCount++;
                    end
                    // A fetched ld brings one data read after it
                    dataReadNext = (mem[memAddr[7:0]][31:27] == ld);
                    fetchAddr = fetchAddr + 32'd1;
                end
            end
            if (outStrobe === 1'b1) begin
                checkCount++;
                if (haltSeen) begin
                    $display("output strobe seen after the CPU halted");
                    errorCount++;
                end
                if (strobeCount >= expected.size()) begin
                    $display("more output strobes than expected values");
                    errorCount++;
                end else if (outPort !== expected[strobeCount]) begin
                    $display("[ERROR] %0t: outPort %h, expected %h", $time, outPort,
                             expected[strobeCount]);
                    errorCount++;
                end
                strobeCount++;
            end
            if (halted === 1'b1) haltSeen = 1'b1;
        end
    end

    initial begin
        rstN = 1'b0;
        errorCount = 0;
        checkCount = 0;
        strobeCount = 0;
        imageTop = 0;
        imageWords = 0;
        fetchAddr = startPc;
        dataReadNext = 1'b0;
        haltSeen = 1'b0;
        imageLoaded = 1'b0;
        loadImage();
        if (imageLoaded !== 1'b1) begin
            $display("CHECKS FAILED");
            $finish;
        end else begin
            // Ten reset cycles, then the idle cycle
            for (int i = 0; i < 11; i++) begin
                @(negedge clock);
                checkQuiet();
                if (i == 9) rstN = 1'b1;
            end
            wait (halted === 1'b1);
            // Quiet window after halt
            repeat (20) @(posedge clock);
            @(negedge clock);
            checkCount++;
            if (strobeCount != expected.size()) begin
                $display("[ERROR] %0t: %0d output strobes, %0d expected", $time, strobeCount,
                         expected.size());
                errorCount++;
            end
            $display("checks %0d, errors %0d, strobes %0d", checkCount, errorCount,
                     strobeCount);
            if (errorCount == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

//--- tests/cpuTop_sva.sv
`timescale 1ns/1ps

module cpuTop_sva (
    input logic              clock,
    input logic              rstN,
    input cpuPkg::ctrlWord_t ctrl,
    input logic              memRead,
    input logic              outStrobe
);

    import cpuPkg::*;

    // Any load from the bus needs exactly one real source on it
    busSourceOnLoad: assert property (@(posedge clock) disable iff (!rstN)
        (ctrl.marIn || ctrl.pcIn || ctrl.irIn || ctrl.yIn || ctrl.zIn || ctrl.regIn
            || ctrl.outIn) |-> ctrl.busSrc inside {srcPc, srcZ, srcMdr, srcReg, srcImm})
        else $error("register load from a bus with no source");

    // Port pulse never stretches
    outStrobeSingle: assert property (@(posedge clock) disable iff (!rstN)
        outStrobe |=> !outStrobe)
        else $error("outStrobe held for more than one cycle");

    // No read in the cycle after a reset edge
    memReadAfterReset: assert property (@(posedge clock) !rstN |=> !memRead)
        else $error("memRead high right after reset");

endmodule

bind cpuTop cpuTop_sva cpuTop_sva_i (
    .clock     (clock),
    .rstN      (rstN),
    .ctrl      (ctrl),
    .memRead   (memRead),
    .outStrobe (outStrobe)
);

//--- tests/cpu_cases.mem
// Columns are tag, address and word on m lines, and tag and next outPort value on e lines
m 00 00800040 ld r1 0x40(r0)
m 01 01000041 ld r2 0x41(r0)
m 02 19890000 add r3 r1 r2
m 03 b9800000 out r3
m 04 21890000 sub r3 r1 r2
m 05 b9800000 out r3
m 06 29890000 and r3 r1 r2
m 07 b9800000 out r3
m 08 31890000 or r3 r1 r2
m 09 b9800000 out r3
m 0a 59890000 shl r3 r1 r2
m 0b b9800000 out r3
m 0c 49890000 shr r3 r1 r2
m 0d b9800000 out r3
m 0e 91890000 not r3 r2
m 0f b9800000 out r3
m 10 89890000 neg r3 r2
m 11 b9800000 out r3
m 12 d0000000 nop
m 13 62087ffe addi r4 r1 -2
m 14 ba000000 out r4
m 15 6a080ff0 andi r4 r1 0x0ff0
m 16 ba000000 out r4
m 17 72104000 ori r4 r2 sign-extended 0x4000
m 18 ba000000 out r4
m 19 60080005 addi r0 r1 5
m 1a b8000000 out r0
m 1b d8000000 halt
m 40 12345678 data for r1
m 41 0000000c data for r2
e 12345684 add
e 1234566c sub
e 00000008 and
e 1234567c or
e 45678000 shl by 12
e 00012345 shr by 12
e fffffff3 not of r2
e fffffff4 neg of r2
e 12345676 addi
e 00000670 andi
e ffffc00c ori
e 00000000 r0 reads zero

//--- vlog.f
logic/cpuPkg.sv
logic/regFile.sv
logic/aluUnit.sv
logic/busDatapath.sv
logic/controlSequencer.sv
logic/cpuTop.sv
tests/cpuTop_sva.sv
tests/cpuTb.sv
